/* src.f */
+incdir+include
design/exec_pkg.sv
design/alu_unit.sv
design/branch_unit.sv
design/ex_mem_reg.sv
design/exec_stage.sv
test/tb_clk_gen.sv
test/tb_exec_stage.sv

/* test/tb_exec_stage.sv */
`timescale 1ns/1ps
`include "exec_defs.svh"

module tb_exec_stage;

  logic clk;
  logic rst_n;
  logic run, ien, write_reg, alu_src_a, alu_src_b, jump;
  exec_pkg::alu_op_e     alu_op;
  exec_pkg::fwd_sel_e    fwd_a, fwd_b;
  exec_pkg::br_type_e    br_type;
  exec_pkg::reg_dst_e    reg_dst;
  exec_pkg::word_t       rd1, rd2, immed, pc, aluout_m2, wb_data;
  exec_pkg::inst_field_t inst_field;
  logic                  br_take, ien_m1, write_reg_m1, br_inst_m1, ov_m1;
  exec_pkg::word_t       branch_target, aluout_m1, src_b_m1;
  exec_pkg::reg_addr_t   reg_dst_addr_m1;
  logic [72:0]           m1_bus;  // every m1 output for the hold check

  exec_pkg::word_t     mdl_a_fwd, mdl_b_fwd, mdl_a, mdl_b, mdl_alu, mdl_pc4;
  exec_pkg::word_t     exp_target, mdl_next_out;
  exec_pkg::reg_addr_t mdl_next_dst;
  logic                mdl_ov, exp_br_take;
  logic                mdl_ien_m1, mdl_write_m1, mdl_br_inst_m1, mdl_ov_m1;
  exec_pkg::word_t     mdl_aluout_m1, mdl_src_b_m1;
  exec_pkg::reg_addr_t mdl_dst_m1;
  int                  load_count = 0;

  tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  exec_stage dut (.*);

  assign m1_bus = {ien_m1, write_reg_m1, br_inst_m1, ov_m1, aluout_m1, src_b_m1, reg_dst_addr_m1};

  function automatic exec_pkg::word_t pick_operand(input exec_pkg::fwd_sel_e sel,
      input exec_pkg::word_t reg_val, input exec_pkg::word_t m1_val,
      input exec_pkg::word_t m2_val, input exec_pkg::word_t wb_val);
    if (sel == exec_pkg::FWD_M1) return m1_val;
    if (sel == exec_pkg::FWD_M2) return m2_val;
    if (sel == exec_pkg::FWD_WB) return wb_val;
    return reg_val;
  endfunction

  // combinational part of the reference model
  always_comb begin
    logic [32:0] wide;
    logic [63:0] ext;
    logic [4:0]  sh;
    mdl_a_fwd = pick_operand(fwd_a, rd1, mdl_aluout_m1, aluout_m2, wb_data);
    mdl_b_fwd = pick_operand(fwd_b, rd2, mdl_aluout_m1, aluout_m2, wb_data);
    mdl_pc4   = pc + `PC_STEP;
    mdl_a     = alu_src_a ? mdl_pc4 : mdl_a_fwd;
    mdl_b     = alu_src_b ? immed : mdl_b_fwd;
    sh        = inst_field[10:6];
    wide      = {mdl_a[31], mdl_a} + {mdl_b[31], mdl_b};  // sign extended sum
    if (alu_op == exec_pkg::SUB || alu_op == exec_pkg::SUBU)
      wide = {mdl_a[31], mdl_a} - {mdl_b[31], mdl_b};
    ext    = {{32{mdl_b[31]}}, mdl_b} >> sh;  // arithmetic shift by hand
    mdl_ov = (alu_op == exec_pkg::ADD || alu_op == exec_pkg::SUB) && (wide[32] != wide[31]);
    case (alu_op)
      exec_pkg::ADD, exec_pkg::ADDU, exec_pkg::SUB, exec_pkg::SUBU: mdl_alu = wide[31:0];
      exec_pkg::AND:  mdl_alu = mdl_a & mdl_b;
      exec_pkg::OR:   mdl_alu = mdl_a | mdl_b;
      exec_pkg::XOR:  mdl_alu = mdl_a ^ mdl_b;
      exec_pkg::NOR:  mdl_alu = ~mdl_a & ~mdl_b;
      exec_pkg::SLT:  mdl_alu = {31'b0, (mdl_a ^ 32'h8000_0000) < (mdl_b ^ 32'h8000_0000)};
      exec_pkg::SLTU: mdl_alu = {31'b0, mdl_a < mdl_b};
      exec_pkg::SLL:  mdl_alu = mdl_b << sh;
      exec_pkg::SRL:  mdl_alu = mdl_b >> sh;
      exec_pkg::SRA:  mdl_alu = ext[31:0];
      exec_pkg::LUI:  mdl_alu = {mdl_b[15:0], 16'h0000};
      default:        mdl_alu = '0;
    endcase
    case (br_type)
      exec_pkg::JR:   exp_br_take = 1'b1;
      exec_pkg::BEQ:  exp_br_take = (mdl_a_fwd == mdl_b_fwd);
      exec_pkg::BNE:  exp_br_take = (mdl_a_fwd != mdl_b_fwd);
      exec_pkg::BLEZ: exp_br_take = ($signed(mdl_a_fwd) <= 0);
      exec_pkg::BLTZ: exp_br_take = ($signed(mdl_a_fwd) < 0);
      exec_pkg::BGEZ: exp_br_take = ($signed(mdl_a_fwd) >= 0);
      exec_pkg::BGTZ: exp_br_take = ($signed(mdl_a_fwd) > 0);
      default:        exp_br_take = 1'b0;  // not a branch
    endcase
    exp_target   = jump ? {mdl_pc4[31:28], inst_field, 2'b00} : mdl_alu;
    mdl_next_out = (br_type != exec_pkg::NORM) ? pc + `RET_OFFSET : mdl_alu;
    case (reg_dst)
      exec_pkg::RT: mdl_next_dst = inst_field[20:16];
      exec_pkg::RD: mdl_next_dst = inst_field[15:11];
      default:      mdl_next_dst = 5'd`RA_REG;
    endcase
  end

  // reference m1 register
  always @(posedge clk) begin
    if (!rst_n) begin
      {mdl_ien_m1, mdl_write_m1, mdl_br_inst_m1, mdl_ov_m1} <= 4'b0;
      mdl_aluout_m1 <= '0;
      mdl_src_b_m1  <= '0;
      mdl_dst_m1    <= '0;
    end else if (run) begin
      mdl_ien_m1     <= ien;
      mdl_write_m1   <= write_reg & ~mdl_ov;  // overflow kills the write
      mdl_br_inst_m1 <= (br_type != exec_pkg::NORM);
      mdl_ov_m1      <= mdl_ov;
      mdl_aluout_m1  <= mdl_next_out;
      mdl_src_b_m1   <= mdl_b_fwd;
      mdl_dst_m1     <= mdl_next_dst;
      load_count     <= load_count + 1;
    end
  end

  task automatic halt_run();
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic stop_on_mismatch(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    $display("FAIL %s got 0x%h exp 0x%h", name, got, exp);
    halt_run();
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    halt_run();
  endtask

  // same cycle outputs
  a_br_take: assert property (@(posedge clk) disable iff (!rst_n) br_take == exp_br_take)
    else stop_on_mismatch("br_take", $sampled(br_take), $sampled(exp_br_take));
  a_target: assert property (@(posedge clk) disable iff (!rst_n) branch_target == exp_target)
    else stop_on_mismatch("branch_target", $sampled(branch_target), $sampled(exp_target));
  // m1 outputs are x on both sides until the first reset edge
  a_aluout: assert property (@(posedge clk) aluout_m1 === mdl_aluout_m1)
    else stop_on_mismatch("aluout_m1", $sampled(aluout_m1), $sampled(mdl_aluout_m1));
  a_src_b: assert property (@(posedge clk) src_b_m1 === mdl_src_b_m1)
    else stop_on_mismatch("src_b_m1", $sampled(src_b_m1), $sampled(mdl_src_b_m1));
  a_dst: assert property (@(posedge clk) reg_dst_addr_m1 === mdl_dst_m1)
    else stop_on_mismatch("reg_dst_addr_m1", $sampled(reg_dst_addr_m1), $sampled(mdl_dst_m1));
  a_ien: assert property (@(posedge clk) ien_m1 === mdl_ien_m1)
    else stop_on_mismatch("ien_m1", $sampled(ien_m1), $sampled(mdl_ien_m1));
  a_write: assert property (@(posedge clk) write_reg_m1 === mdl_write_m1)
    else stop_on_mismatch("write_reg_m1", $sampled(write_reg_m1), $sampled(mdl_write_m1));
  a_br_inst: assert property (@(posedge clk) br_inst_m1 === mdl_br_inst_m1)
    else stop_on_mismatch("br_inst_m1", $sampled(br_inst_m1), $sampled(mdl_br_inst_m1));
  a_ov: assert property (@(posedge clk) ov_m1 === mdl_ov_m1)
    else stop_on_mismatch("ov_m1", $sampled(ov_m1), $sampled(mdl_ov_m1));
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      ($past(rst_n) && !$past(run)) |-> (m1_bus == $past(m1_bus)))
    else abort_run("M1 outputs changed while run was low");

  task automatic set_defaults();  // plain register add without a branch
    {run, ien, write_reg} = 3'b111;
    {alu_src_a, alu_src_b, jump} = 3'b000;
    alu_op  = exec_pkg::ADD;
    fwd_a   = exec_pkg::NO_FWD;
    fwd_b   = exec_pkg::NO_FWD;
    br_type = exec_pkg::NORM;
    reg_dst = exec_pkg::RD;
  endtask

  task automatic set_random_data();
    rd1        = $urandom;
    rd2        = $urandom;
    immed      = $urandom;
    pc         = $urandom & 32'hffff_fffc;  // word aligned
    inst_field = $urandom;
    aluout_m2  = $urandom;
    wb_data    = $urandom;
  endtask

  task automatic wait_falls(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(negedge clk);
      seen++;
    end
  endtask

  // returns on the falling edge after the case loads into m1
  task automatic issue_case();
    int target;
    int waited;
    target = load_count + 1;
    waited = 0;
    while (load_count < target) begin
      @(negedge clk);
      waited++;
      if (waited > 8) abort_run("timeout waiting for the M1 register to load");
    end
  endtask

  initial begin
    int waited;
    exec_pkg::word_t fwd_val;
    void'($urandom(32'h7388_721e));
    set_defaults();
    set_random_data();
    run = 1'b0;  // nothing loads until reset is done
    waited = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > 20) abort_run("timeout waiting for reset release");
    end
    for (int i = 0; i < 3; i++) begin  // idle after reset so the flags stay low
      set_random_data();
      wait_falls(1);
    end
    run = 1'b1;
    for (int op = 0; op < 14; op++) begin  // every alu op with every source select
      for (int s = 0; s < 4; s++) begin
        set_random_data();
        alu_op    = exec_pkg::alu_op_e'(op);
        {alu_src_a, alu_src_b} = s[1:0];
        reg_dst   = exec_pkg::reg_dst_e'($urandom_range(2, 0));
        ien       = $urandom;
        write_reg = $urandom;
        issue_case();
      end
    end
    set_defaults();
    for (int k = 0; k < 3; k++) begin  // add, sub, then addu on overflowing values
      set_random_data();
      alu_op = (k == 0) ? exec_pkg::ADD : (k == 1) ? exec_pkg::SUB : exec_pkg::ADDU;
      rd1    = (k == 1) ? 32'h8000_0000 : 32'h7fff_ffff;
      rd2    = 32'h0000_0001;
      issue_case();
    end
    run = 1'b0;  // stall with the inputs moving
    for (int i = 0; i < 4; i++) begin
      set_random_data();
      alu_op = exec_pkg::alu_op_e'($urandom_range(13, 0));
      wait_falls(1);
    end
    run = 1'b1;
    for (int sel = 1; sel < 4; sel++) begin
      set_defaults();
      set_random_data();
      fwd_a = exec_pkg::fwd_sel_e'(sel);
      issue_case();
      set_defaults();
      set_random_data();
      alu_op = exec_pkg::SUB;
      fwd_b  = exec_pkg::fwd_sel_e'(sel);
      issue_case();
      for (int eq = 0; eq < 2; eq++) begin  // beq taken then not taken
        set_defaults();
        set_random_data();
        br_type = exec_pkg::BEQ;
        fwd_a   = exec_pkg::fwd_sel_e'(sel);
        fwd_val = pick_operand(fwd_a, rd1, mdl_aluout_m1, aluout_m2, wb_data);
        rd2     = (eq == 0) ? fwd_val : fwd_val ^ 32'h1;
        issue_case();
      end
    end
    for (int bt = 0; bt < 8; bt++) begin
      for (int v = 0; v < 5; v++) begin
        set_defaults();
        set_random_data();
        br_type   = exec_pkg::br_type_e'(bt);
        {alu_src_a, alu_src_b} = 2'b11;  // pc + 4 + offset
        immed     = {{14{immed[15]}}, immed[15:0], 2'b00};
        jump      = $urandom;
        if (v == 1) rd2 = rd1;
        if (v == 2) rd1 = '0;
        if (v == 3) rd1 = rd1 | 32'h8000_0000;
        if (v == 4) rd1 = (rd1 & 32'h7fff_ffff) | 32'h1;
        issue_case();
      end
    end
    for (int bt = 1; bt < 8; bt++) begin  // link cases
      set_defaults();
      set_random_data();
      br_type = exec_pkg::br_type_e'(bt);
      reg_dst = exec_pkg::RA;
      jump    = (bt == 1);
      issue_case();
    end
    set_defaults();
    wait_falls(2);  // last load gets checked
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* test/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);  // five reset edges
    @(negedge clk);
    rst_n = 1'b1;  // release away from the sampling edge
  end

endmodule

/* design/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  run,
  input  logic                  ien,
  input  logic                  write_reg,
  input  exec_pkg::alu_op_e     alu_op,
  input  logic                  alu_src_a,
  input  logic                  alu_src_b,
  input  exec_pkg::fwd_sel_e    fwd_a,            // from hazard logic
  input  exec_pkg::fwd_sel_e    fwd_b,
  input  exec_pkg::br_type_e    br_type,
  input  logic                  jump,
  input  exec_pkg::reg_dst_e    reg_dst,
  input  exec_pkg::word_t       rd1,
  input  exec_pkg::word_t       rd2,
  input  exec_pkg::word_t       immed,
  input  exec_pkg::word_t       pc,
  input  exec_pkg::inst_field_t inst_field,
  input  exec_pkg::word_t       aluout_m2,        // m2 forwarding source
  input  exec_pkg::word_t       wb_data,          // wb forwarding source
  output logic                  br_take,          // same cycle
  output exec_pkg::word_t       branch_target,    // same cycle
  output logic                  ien_m1,
  output logic                  write_reg_m1,
  output exec_pkg::word_t       aluout_m1,
  output exec_pkg::word_t       src_b_m1,
  output exec_pkg::reg_addr_t   reg_dst_addr_m1,
  output logic                  br_inst_m1,
  output logic                  ov_m1
);

  exec_pkg::word_t src_a_fwd;
  exec_pkg::word_t src_b_fwd;
  exec_pkg::word_t alu_result;
  exec_pkg::word_t ret_addr;
  logic            ov;
  logic            br_inst;

  alu_unit u_alu (
    .alu_op     (alu_op),
    .alu_src_a  (alu_src_a),
    .alu_src_b  (alu_src_b),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .rd1        (rd1),
    .rd2        (rd2),
    .immed      (immed),
    .pc         (pc),
    .aluout_m1  (aluout_m1),  // loops back from the m1 register
    .aluout_m2  (aluout_m2),
    .wb_data    (wb_data),
    .inst_field (inst_field),
    .src_a_fwd  (src_a_fwd),
    .src_b_fwd  (src_b_fwd),
    .alu_result (alu_result),
    .ov         (ov)
  );

  branch_unit u_branch (
    .br_type       (br_type),
    .jump          (jump),
    .src_a_fwd     (src_a_fwd),
    .src_b_fwd     (src_b_fwd),
    .alu_result    (alu_result),  // alu computes the branch offset sum
    .pc            (pc),
    .inst_field    (inst_field),
    .br_take       (br_take),
    .br_inst       (br_inst),
    .branch_target (branch_target),
    .ret_addr      (ret_addr)
  );

  ex_mem_reg u_m1_reg (
    .clk             (clk),
    .rst_n           (rst_n),
    .run             (run),
    .ien             (ien),
    .write_reg       (write_reg),
    .reg_dst         (reg_dst),
    .inst_field      (inst_field),
    .alu_result      (alu_result),
    .src_b_fwd       (src_b_fwd),
    .ret_addr        (ret_addr),
    .br_inst         (br_inst),
    .ov              (ov),
    .ien_m1          (ien_m1),
    .write_reg_m1    (write_reg_m1),
    .br_inst_m1      (br_inst_m1),
    .ov_m1           (ov_m1),
    .aluout_m1       (aluout_m1),
    .src_b_m1        (src_b_m1),
    .reg_dst_addr_m1 (reg_dst_addr_m1)
  );

endmodule

/* design/ex_mem_reg.sv */
`timescale 1ns/1ps
`include "exec_defs.svh"

module ex_mem_reg (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  run,              // load enable
  input  logic                  ien,              // instruction valid
  input  logic                  write_reg,        // regfile write request
  input  exec_pkg::reg_dst_e    reg_dst,          // destination select
  input  exec_pkg::inst_field_t inst_field,       // rt and rd fields
  input  exec_pkg::word_t       alu_result,
  input  exec_pkg::word_t       src_b_fwd,        // store data
  input  exec_pkg::word_t       ret_addr,         // link value
  input  logic                  br_inst,
  input  logic                  ov,
  output logic                  ien_m1,
  output logic                  write_reg_m1,
  output logic                  br_inst_m1,
  output logic                  ov_m1,
  output exec_pkg::word_t       aluout_m1,
  output exec_pkg::word_t       src_b_m1,
  output exec_pkg::reg_addr_t   reg_dst_addr_m1
);

  exec_pkg::word_t     result;         // value headed for m1
  exec_pkg::reg_addr_t reg_dst_addr;
  logic                write_reg_ok;   // write request after overflow check

  // branches and jumps carry the link address
  assign result = br_inst ? ret_addr : alu_result;

  always_comb begin
    case (reg_dst)
      exec_pkg::RT: reg_dst_addr = inst_field[20:16];
      exec_pkg::RD: reg_dst_addr = inst_field[15:11];
      default:      reg_dst_addr = exec_pkg::reg_addr_t'(`RA_REG);  // link
    endcase
  end

  assign write_reg_ok = write_reg & ~ov;  // no commit on overflow

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ien_m1          <= 1'b0;
      write_reg_m1    <= 1'b0;
      br_inst_m1      <= 1'b0;
      ov_m1           <= 1'b0;
      aluout_m1       <= '0;
      src_b_m1        <= '0;
      reg_dst_addr_m1 <= '0;
    end else if (run) begin  // hold everything while stopped
      ien_m1          <= ien;
      write_reg_m1    <= write_reg_ok;
      br_inst_m1      <= br_inst;
      ov_m1           <= ov;
      aluout_m1       <= result;
      src_b_m1        <= src_b_fwd;
      reg_dst_addr_m1 <= reg_dst_addr;
    end
  end

endmodule

/* design/branch_unit.sv */
`timescale 1ns/1ps
`include "exec_defs.svh"

module branch_unit (
  input  exec_pkg::br_type_e    br_type,        // branch condition
  input  logic                  jump,           // j or jal
  input  exec_pkg::word_t       src_a_fwd,      // resolved rs
  input  exec_pkg::word_t       src_b_fwd,      // resolved rt
  input  exec_pkg::word_t       alu_result,     // pc+4 + offset, or rs for jr
  input  exec_pkg::word_t       pc,
  input  exec_pkg::inst_field_t inst_field,     // jump index
  output logic                  br_take,        // redirect fetch
  output logic                  br_inst,        // any branch or jump
  output exec_pkg::word_t       branch_target,  // where fetch goes
  output exec_pkg::word_t       ret_addr        // link value
);

  exec_pkg::word_t pc_plus_step;
  exec_pkg::word_t jump_target;
  logic            regs_equal;
  logic            reg_zero;
  logic            reg_neg;

  assign pc_plus_step = pc + `PC_STEP;

  // region of pc+4, then the index, word aligned
  assign jump_target = {pc_plus_step[`XLEN-1:`XLEN-4], inst_field, 2'b00};

  assign branch_target = jump ? jump_target : alu_result;

  // compare flags, all from the forwarded operands
  assign regs_equal = (src_a_fwd == src_b_fwd);
  assign reg_zero   = (src_a_fwd == '0);
  assign reg_neg    = src_a_fwd[`XLEN-1];  // sign bit

  always_comb begin
    case (br_type)
      exec_pkg::NORM: br_take = 1'b0;
      exec_pkg::JR:   br_take = 1'b1;  // jr and plain jumps
      exec_pkg::BEQ:  br_take = regs_equal;
      exec_pkg::BNE:  br_take = ~regs_equal;
      exec_pkg::BLEZ: br_take = reg_neg | reg_zero;
      exec_pkg::BLTZ: br_take = reg_neg;
      exec_pkg::BGEZ: br_take = ~reg_neg;
      exec_pkg::BGTZ: br_take = ~reg_neg & ~reg_zero;
      default:        br_take = 1'b0;
    endcase
  end

  assign br_inst = (br_type != exec_pkg::NORM);

  // return past the delay slot
  assign ret_addr = pc + `RET_OFFSET;

endmodule

/* design/alu_unit.sv */
`timescale 1ns/1ps
`include "exec_defs.svh"

module alu_unit (
  input  exec_pkg::alu_op_e     alu_op,      // operation select
  input  logic                  alu_src_a,   // pc+4 in place of rs
  input  logic                  alu_src_b,   // immediate in place of rt
  input  exec_pkg::fwd_sel_e    fwd_a,       // forwarding for rs
  input  exec_pkg::fwd_sel_e    fwd_b,       // forwarding for rt
  input  exec_pkg::word_t       rd1,         // regfile rs value
  input  exec_pkg::word_t       rd2,         // regfile rt value
  input  exec_pkg::word_t       immed,       // extended immediate
  input  exec_pkg::word_t       pc,          // pc of this instruction
  input  exec_pkg::word_t       aluout_m1,   // m1 result, fed back
  input  exec_pkg::word_t       aluout_m2,   // m2 result
  input  exec_pkg::word_t       wb_data,     // writeback data
  input  exec_pkg::inst_field_t inst_field,  // shamt lives in here
  output exec_pkg::word_t       src_a_fwd,   // resolved rs
  output exec_pkg::word_t       src_b_fwd,   // resolved rt
  output exec_pkg::word_t       alu_result,
  output logic                  ov           // signed overflow
);

  exec_pkg::word_t src_a;   // alu operand a
  exec_pkg::word_t src_b;   // alu operand b
  exec_pkg::word_t sum;
  exec_pkg::word_t diff;
  logic [4:0]      shamt;
  logic            ov_add;
  logic            ov_sub;
  logic            lt_signed;
  logic            lt_unsigned;

  // one forwarding mux, used for both operands
  function automatic exec_pkg::word_t fwd_pick(
    input exec_pkg::fwd_sel_e sel,
    input exec_pkg::word_t    reg_val,
    input exec_pkg::word_t    m1_val,
    input exec_pkg::word_t    m2_val,
    input exec_pkg::word_t    wb_val
  );
    case (sel)
      exec_pkg::FWD_M1: fwd_pick = m1_val;
      exec_pkg::FWD_M2: fwd_pick = m2_val;
      exec_pkg::FWD_WB: fwd_pick = wb_val;
      default:          fwd_pick = reg_val;  // no forwarding
    endcase
  endfunction

  assign src_a_fwd = fwd_pick(fwd_a, rd1, aluout_m1, aluout_m2, wb_data);
  assign src_b_fwd = fwd_pick(fwd_b, rd2, aluout_m1, aluout_m2, wb_data);

  assign src_a = alu_src_a ? (pc + `PC_STEP) : src_a_fwd;  // pc+4 for branch targets
  assign src_b = alu_src_b ? immed : src_b_fwd;

  assign shamt = inst_field[10:6];

  assign sum  = src_a + src_b;
  assign diff = src_a - src_b;

  // same sign in, other sign out
  assign ov_add = (src_a[`XLEN-1] == src_b[`XLEN-1]) & (sum[`XLEN-1] != src_a[`XLEN-1]);
  // opposite signs in, result sign differs from a
  assign ov_sub = (src_a[`XLEN-1] != src_b[`XLEN-1]) & (diff[`XLEN-1] != src_a[`XLEN-1]);

  assign lt_signed   = $signed(src_a) < $signed(src_b);
  assign lt_unsigned = src_a < src_b;

  always_comb begin
    case (alu_op)
      exec_pkg::ADD,
      exec_pkg::ADDU: alu_result = sum;
      exec_pkg::SUB,
      exec_pkg::SUBU: alu_result = diff;
      exec_pkg::AND:  alu_result = src_a & src_b;
      exec_pkg::OR:   alu_result = src_a | src_b;
      exec_pkg::XOR:  alu_result = src_a ^ src_b;
      exec_pkg::NOR:  alu_result = ~(src_a | src_b);
      exec_pkg::SLT:  alu_result = exec_pkg::word_t'(lt_signed);    // 0 or 1
      exec_pkg::SLTU: alu_result = exec_pkg::word_t'(lt_unsigned);
      exec_pkg::SLL:  alu_result = src_b << shamt;   // shifts work on rt
      exec_pkg::SRL:  alu_result = src_b >> shamt;
      exec_pkg::SRA:  alu_result = exec_pkg::word_t'($signed(src_b) >>> shamt);
      exec_pkg::LUI:  alu_result = {src_b[`XLEN/2-1:0], {(`XLEN/2){1'b0}}};
      default:        alu_result = '0;
    endcase
  end

  // only the trapping forms report overflow
  assign ov = ((alu_op == exec_pkg::ADD) & ov_add) |
              ((alu_op == exec_pkg::SUB) & ov_sub);

endmodule

/* design/exec_pkg.sv */
`include "exec_defs.svh"

package exec_pkg;

  typedef logic [`XLEN-1:0]         word_t;        // one data word
  typedef logic [`REG_ADDR_W-1:0]   reg_addr_t;    // register file index
  typedef logic [`INST_FIELD_W-1:0] inst_field_t;  // inst bits 25..0

  // alu operations, decoded upstream
  typedef enum logic [`ALU_OP_W-1:0] {
    ADD, ADDU, SUB, SUBU,
    AND, OR, XOR, NOR,
    SLT, SLTU,
    SLL, SRL, SRA,
    LUI
  } alu_op_e;

  typedef enum logic [`BR_TYPE_W-1:0] {
    NORM = 3'd0,  // not a branch
    JR   = 3'd1,  // unconditional
    BEQ  = 3'd2,
    BNE  = 3'd3,
    BLEZ = 3'd4,
    BLTZ = 3'd5,
    BGEZ = 3'd6,
    BGTZ = 3'd7
  } br_type_e;

  typedef enum logic [`FWD_SEL_W-1:0] {
    NO_FWD = 2'd0,  // regfile value
    FWD_M1 = 2'd1,  // from m1 register
    FWD_M2 = 2'd2,  // from m2 stage
    FWD_WB = 2'd3   // from writeback
  } fwd_sel_e;

  typedef enum logic [1:0] {
    RT = 2'd0,  // i-type destination
    RD = 2'd1,  // r-type destination
    RA = 2'd2   // link
  } reg_dst_e;

endpackage

/* include/exec_defs.svh */
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// data path and register file geometry
`define XLEN          32  // word width
`define REG_ADDR_W    5   // register index width
`define RA_REG        31  // link register for jal and bal

// pc arithmetic
`define PC_STEP       4   // next sequential instruction
`define RET_OFFSET    8   // skips the delay slot

// low instruction bits carried into execute
`define INST_FIELD_W  26  // rs rt rd shamt or jump index

// control field widths
`define ALU_OP_W      4   // alu operation code
`define BR_TYPE_W     3   // branch condition code
`define FWD_SEL_W     2   // forwarding mux select

`endif
